//--- flist.f
source/kv_pkg.sv
source/kv_fsm.sv
source/kv_client.sv
source/kv_store.sv
source/kv_mix_core.sv
source/kv_subsys_top.sv
tb/kv_tb.sv

//--- run.sh
#!/bin/sh
# build and run the key vault testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --timescale 1ns/1ps \
   --top-module kv_tb \
   -f flist.f \
   -o kv_tb_sim

./obj_dir/kv_tb_sim 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
   echo "simulation ended without a pass"
   exit 1
fi
echo "simulation passed"

//--- source/kv_client.sv
`timescale 1ns/1ps
`default_nettype none

module kv_client #(
   parameter  int DATA_WIDTH = 256,
   localparam int NUM_DWORDS = DATA_WIDTH / 32
) (
   input  logic                            clk,
   input  logic                            reset,

   input  kv_pkg::kv_reg_t                 client_ctrl_reg,

   output kv_pkg::kv_read_t                kv_read,
   output kv_pkg::kv_write_t               kv_write,
   input  kv_pkg::kv_resp_t                kv_resp,

   output logic                            key_write_en,
   output logic [kv_pkg::KV_OFFSET_W-1:0]  key_write_offset,
   output logic [31:0]                     key_write_data,
   output logic                            src_write_en,
   output logic [kv_pkg::KV_OFFSET_W-1:0]  src_write_offset,
   output logic [31:0]                     src_write_data,

   input  logic                            dest_data_avail,
   input  logic [NUM_DWORDS-1:0][31:0]     dest_data,

   output logic                            key_done,
   output logic                            src_done,
   output logic                            dest_done
);
   import kv_pkg::*;

   localparam logic [KV_OFFSET_W-1:0] LAST_OFFSET = KV_OFFSET_W'(NUM_DWORDS - 1);

   logic [KV_OFFSET_W-1:0] key_read_offset;
   logic [KV_OFFSET_W-1:0] src_read_offset;
   logic [KV_OFFSET_W-1:0] dest_read_offset;
   logic [KV_OFFSET_W-1:0] dest_write_offset;
   logic [KV_OFFSET_W-1:0] dest_index;
   logic                   dest_write_en;
   logic                   dest_start;

   // key read
   kv_fsm #(
      .DATA_WIDTH(DATA_WIDTH)
   ) kv_key_read_fsm (
      .clk          (clk),
      .reset        (reset),
      .start        (client_ctrl_reg.key_sel_en),
      .read_offset  (key_read_offset),
      .write_en     (key_write_en),
      .write_offset (key_write_offset),
      .done         (key_done)
   );

   always_comb begin
      kv_read.key_is_pcr = client_ctrl_reg.key_sel_pcr;
      kv_read.key_entry  = client_ctrl_reg.key_sel;
      kv_read.key_offset = key_read_offset;
   end

   assign key_write_data = kv_resp.key_data;

   // source read
   kv_fsm #(
      .DATA_WIDTH(DATA_WIDTH)
   ) kv_src_read_fsm (
      .clk          (clk),
      .reset        (reset),
      .start        (client_ctrl_reg.src_sel_en),
      .read_offset  (src_read_offset),
      .write_en     (src_write_en),
      .write_offset (src_write_offset),
      .done         (src_done)
   );

   always_comb begin
      kv_read.src_is_pcr = client_ctrl_reg.src_sel_pcr;
      kv_read.src_entry  = client_ctrl_reg.src_sel;
      kv_read.src_offset = src_read_offset;
   end

   assign src_write_data = kv_resp.src_data;

   // write-back waits for a result and an enabled destination
   assign dest_start = dest_data_avail & client_ctrl_reg.dest_sel_en;

   kv_fsm #(
      .DATA_WIDTH(DATA_WIDTH)
   ) kv_dest_write_fsm (
      .clk          (clk),
      .reset        (reset),
      .start        (dest_start),
      .read_offset  (dest_read_offset),
      .write_en     (dest_write_en),
      .write_offset (dest_write_offset),
      .done         (dest_done)
   );

   // dword 0 sits in the top slot of the result
   assign dest_index = LAST_OFFSET - dest_read_offset;

   always_comb begin
      kv_write.dest_is_pcr = client_ctrl_reg.dest_sel_pcr;
      kv_write.dest_addr   = client_ctrl_reg.dest_sel;
      kv_write.dest_offset = dest_write_offset;
      kv_write.dest_wr_vld = dest_write_en;
      kv_write.dest_data   = dest_data[dest_index];
      kv_write.dest_valid  = client_ctrl_reg.dest_valid;
   end

endmodule

`default_nettype wire

//--- source/kv_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module kv_fsm #(
   parameter int DATA_WIDTH = 256
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           start,
   output logic [kv_pkg::KV_OFFSET_W-1:0] read_offset,
   output logic                           write_en,
   output logic [kv_pkg::KV_OFFSET_W-1:0] write_offset,
   output logic                           done
);
   import kv_pkg::*;

   localparam int NUM_DWORDS = DATA_WIDTH / 32;
   localparam logic [KV_OFFSET_W-1:0] LAST_OFFSET = KV_OFFSET_W'(NUM_DWORDS - 1);

   logic                   start_q;
   logic                   start_rise;
   logic                   busy;
   logic [KV_OFFSET_W-1:0] offset;

   // only a fresh rising edge opens a transfer
   assign start_rise = start & ~start_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         start_q <= 1'b0;
         busy    <= 1'b0;
         offset  <= '0;
         done    <= 1'b0;
      end else begin
         start_q <= start;
         done    <= 1'b0;
         if (busy) begin
            if (offset == LAST_OFFSET) begin
               // final dword, close the burst
               busy   <= 1'b0;
               offset <= '0;
               done   <= 1'b1;
            end else begin
               offset <= offset + 1'b1;
            end
         end else if (start_rise) begin
            busy   <= 1'b1;
            offset <= '0;
         end
      end
   end

   assign read_offset = offset;

   // vault read is combinational, so the write lands in the same cycle
   assign write_en     = busy;
   assign write_offset = read_offset;

   // done closes a burst and never overlaps it
   assert property (@(posedge clk) disable iff (reset)
      done |-> !write_en);

endmodule

`default_nettype wire

//--- source/kv_mix_core.sv
`timescale 1ns/1ps
`default_nettype none

module kv_mix_core #(
   parameter  int DATA_WIDTH = 256,
   localparam int NUM_DWORDS = DATA_WIDTH / 32
) (
   input  logic                           clk,
   input  logic                           reset,

   input  logic                           key_write_en,
   input  logic [kv_pkg::KV_OFFSET_W-1:0] key_write_offset,
   input  logic [31:0]                    key_write_data,
   input  logic                           src_write_en,
   input  logic [kv_pkg::KV_OFFSET_W-1:0] src_write_offset,
   input  logic [31:0]                    src_write_data,

   input  logic                           key_done,
   input  logic                           src_done,
   input  logic                           dest_done,

   output logic                           dest_data_avail,
   output logic [NUM_DWORDS-1:0][31:0]    dest_data
);
   import kv_pkg::*;

   localparam logic [KV_OFFSET_W-1:0] LAST_OFFSET = KV_OFFSET_W'(NUM_DWORDS - 1);

   logic [NUM_DWORDS-1:0][31:0] key_reg;
   logic [NUM_DWORDS-1:0][31:0] src_reg;
   logic [NUM_DWORDS-1:0][31:0] mix;
   logic                        key_seen;
   logic                        src_seen;
   logic                        both_done;

   // first dword lands in the top slot
   always_ff @(posedge clk) begin
      if (key_write_en) begin
         key_reg[LAST_OFFSET - key_write_offset] <= key_write_data;
      end
      if (src_write_en) begin
         src_reg[LAST_OFFSET - src_write_offset] <= src_write_data;
      end
      if (both_done) begin
         dest_data <= mix;
      end
   end

   // key xor source rotated left by 8
   always_comb begin
      for (int i = 0; i < NUM_DWORDS; i++) begin
         mix[i] = key_reg[i] ^ {src_reg[i][23:0], src_reg[i][31:24]};
      end
   end

   // a pulse in flight counts as seen
   assign both_done = (key_seen | key_done) & (src_seen | src_done);

   always_ff @(posedge clk) begin
      if (reset) begin
         key_seen        <= 1'b0;
         src_seen        <= 1'b0;
         dest_data_avail <= 1'b0;
      end else begin
         key_seen <= (key_seen | key_done) & ~both_done;
         src_seen <= (src_seen | src_done) & ~both_done;
         if (both_done) begin
            dest_data_avail <= 1'b1;
         end else if (dest_done) begin
            dest_data_avail <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/kv_pkg.sv
`default_nettype none

package kv_pkg;

   // vault geometry
   localparam int KV_NUM_KEYS     = 8;
   localparam int KV_NUM_PCRS     = 4;
   localparam int KV_ENTRY_DWORDS = 8;
   localparam int KV_ENTRY_W      = 3;
   localparam int KV_OFFSET_W     = 3;

   // client control register, written by firmware
   typedef struct packed {
      logic                  key_sel_en;
      logic                  key_sel_pcr;
      logic [KV_ENTRY_W-1:0] key_sel;
      logic                  src_sel_en;
      logic                  src_sel_pcr;
      logic [KV_ENTRY_W-1:0] src_sel;
      logic                  dest_sel_en;
      logic                  dest_sel_pcr;
      logic [KV_ENTRY_W-1:0] dest_sel;
      logic                  dest_valid;
   } kv_reg_t;

   // both read requests toward the vault
   typedef struct packed {
      logic                   key_is_pcr;
      logic [KV_ENTRY_W-1:0]  key_entry;
      logic [KV_OFFSET_W-1:0] key_offset;
      logic                   src_is_pcr;
      logic [KV_ENTRY_W-1:0]  src_entry;
      logic [KV_OFFSET_W-1:0] src_offset;
   } kv_read_t;

   // write-back request, one dword per cycle
   typedef struct packed {
      logic                   dest_is_pcr;
      logic [KV_ENTRY_W-1:0]  dest_addr;
      logic [KV_OFFSET_W-1:0] dest_offset;
      logic                   dest_wr_vld;
      logic [31:0]            dest_data;
      logic                   dest_valid;
   } kv_write_t;

   // read response, same cycle as the offsets
   typedef struct packed {
      logic [31:0] key_data;
      logic [31:0] src_data;
   } kv_resp_t;

endpackage

`default_nettype wire

//--- source/kv_store.sv
`timescale 1ns/1ps
`default_nettype none

module kv_store (
   input  logic                           clk,
   input  logic                           reset,

   input  kv_pkg::kv_read_t               kv_read,
   output kv_pkg::kv_resp_t               kv_resp,
   input  kv_pkg::kv_write_t              kv_write,

   input  logic                           host_wr_en,
   input  logic                           host_wr_pcr,
   input  logic [kv_pkg::KV_ENTRY_W-1:0]  host_wr_entry,
   input  logic [kv_pkg::KV_OFFSET_W-1:0] host_wr_offset,
   input  logic [31:0]                    host_wr_data,
   input  logic                           host_rd_pcr,
   input  logic [kv_pkg::KV_ENTRY_W-1:0]  host_rd_entry,
   input  logic [kv_pkg::KV_OFFSET_W-1:0] host_rd_offset,
   output logic [31:0]                    host_rd_data
);
   import kv_pkg::*;

   localparam int PCR_W = $clog2(KV_NUM_PCRS);
   localparam logic [KV_ENTRY_W-1:0] PCR_LIMIT = KV_ENTRY_W'(KV_NUM_PCRS);

   logic [31:0]            key_bank [KV_NUM_KEYS][KV_ENTRY_DWORDS];
   logic [31:0]            pcr_bank [KV_NUM_PCRS][KV_ENTRY_DWORDS];
   logic [KV_NUM_KEYS-1:0] key_valid;
   logic [KV_NUM_PCRS-1:0] pcr_valid;

   logic                   wr_en;
   logic                   wr_pcr;
   logic [KV_ENTRY_W-1:0]  wr_entry;
   logic [KV_OFFSET_W-1:0] wr_offset;
   logic [31:0]            wr_data;
   logic                   wr_valid;

   // single write port, client write-back has priority over the host
   assign wr_en = kv_write.dest_wr_vld | host_wr_en;

   always_comb begin
      if (kv_write.dest_wr_vld) begin
         wr_pcr    = kv_write.dest_is_pcr;
         wr_entry  = kv_write.dest_addr;
         wr_offset = kv_write.dest_offset;
         wr_data   = kv_write.dest_data;
         wr_valid  = kv_write.dest_valid;
      end else begin
         wr_pcr    = host_wr_pcr;
         wr_entry  = host_wr_entry;
         wr_offset = host_wr_offset;
         wr_data   = host_wr_data;
         wr_valid  = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         if (wr_pcr) begin
            pcr_bank[wr_entry[PCR_W-1:0]][wr_offset] <= wr_data;
         end else begin
            key_bank[wr_entry][wr_offset] <= wr_data;
         end
      end
   end

   // valid bit follows every dword, so it settles with the last one
   always_ff @(posedge clk) begin
      if (reset) begin
         key_valid <= '0;
         pcr_valid <= '0;
      end else if (wr_en) begin
         if (wr_pcr) begin
            pcr_valid[wr_entry[PCR_W-1:0]] <= wr_valid;
         end else begin
            key_valid[wr_entry] <= wr_valid;
         end
      end
   end

   // invalid entries read as zero
   function automatic logic [31:0] read_dword(input logic                   is_pcr,
                                              input logic [KV_ENTRY_W-1:0]  entry,
                                              input logic [KV_OFFSET_W-1:0] offset);
      logic [31:0] data;
      data = '0;
      if (is_pcr) begin
         if (pcr_valid[entry[PCR_W-1:0]]) begin
            data = pcr_bank[entry[PCR_W-1:0]][offset];
         end
      end else if (key_valid[entry]) begin
         data = key_bank[entry][offset];
      end
      return data;
   endfunction

   always_comb begin
      kv_resp.key_data = read_dword(kv_read.key_is_pcr, kv_read.key_entry, kv_read.key_offset);
      kv_resp.src_data = read_dword(kv_read.src_is_pcr, kv_read.src_entry, kv_read.src_offset);
   end

   // key bank is never visible to the host
   assign host_rd_data = host_rd_pcr ? read_dword(1'b1, host_rd_entry, host_rd_offset) : '0;

   // pcr bank is smaller than the entry index range
   assert property (@(posedge clk) disable iff (reset)
      !((kv_read.key_is_pcr && (kv_read.key_entry >= PCR_LIMIT)) ||
        (kv_read.src_is_pcr && (kv_read.src_entry >= PCR_LIMIT)) ||
        (wr_en && wr_pcr && (wr_entry >= PCR_LIMIT)) ||
        (host_rd_pcr && (host_rd_entry >= PCR_LIMIT))));

   // host must stay off the port during a write-back
   assert property (@(posedge clk) disable iff (reset)
      host_wr_en |-> !kv_write.dest_wr_vld);

endmodule

`default_nettype wire

//--- source/kv_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module kv_subsys_top #(
   parameter int DATA_WIDTH = 256
) (
   input  logic                           clk,
   input  logic                           reset,

   input  kv_pkg::kv_reg_t                client_ctrl_reg,

   input  logic                           host_wr_en,
   input  logic                           host_wr_pcr,
   input  logic [kv_pkg::KV_ENTRY_W-1:0]  host_wr_entry,
   input  logic [kv_pkg::KV_OFFSET_W-1:0] host_wr_offset,
   input  logic [31:0]                    host_wr_data,
   input  logic                           host_rd_pcr,
   input  logic [kv_pkg::KV_ENTRY_W-1:0]  host_rd_entry,
   input  logic [kv_pkg::KV_OFFSET_W-1:0] host_rd_offset,
   output logic [31:0]                    host_rd_data,

   output logic                           key_done,
   output logic                           src_done,
   output logic                           dest_done
);
   import kv_pkg::*;

   localparam int NUM_DWORDS   = DATA_WIDTH / 32;
   // read, then mix, then write-back
   localparam int XFER_LATENCY = 2 * NUM_DWORDS + 3;

   kv_read_t                    kv_read;
   kv_write_t                   kv_write;
   kv_resp_t                    kv_resp;
   logic                        key_write_en;
   logic [KV_OFFSET_W-1:0]      key_write_offset;
   logic [31:0]                 key_write_data;
   logic                        src_write_en;
   logic [KV_OFFSET_W-1:0]      src_write_offset;
   logic [31:0]                 src_write_data;
   logic                        dest_data_avail;
   logic [NUM_DWORDS-1:0][31:0] dest_data;

   kv_client #(
      .DATA_WIDTH(DATA_WIDTH)
   ) u_client (
      .clk              (clk),
      .reset            (reset),
      .client_ctrl_reg  (client_ctrl_reg),
      .kv_read          (kv_read),
      .kv_write         (kv_write),
      .kv_resp          (kv_resp),
      .key_write_en     (key_write_en),
      .key_write_offset (key_write_offset),
      .key_write_data   (key_write_data),
      .src_write_en     (src_write_en),
      .src_write_offset (src_write_offset),
      .src_write_data   (src_write_data),
      .dest_data_avail  (dest_data_avail),
      .dest_data        (dest_data),
      .key_done         (key_done),
      .src_done         (src_done),
      .dest_done        (dest_done)
   );

   kv_store u_store (
      .clk            (clk),
      .reset          (reset),
      .kv_read        (kv_read),
      .kv_resp        (kv_resp),
      .kv_write       (kv_write),
      .host_wr_en     (host_wr_en),
      .host_wr_pcr    (host_wr_pcr),
      .host_wr_entry  (host_wr_entry),
      .host_wr_offset (host_wr_offset),
      .host_wr_data   (host_wr_data),
      .host_rd_pcr    (host_rd_pcr),
      .host_rd_entry  (host_rd_entry),
      .host_rd_offset (host_rd_offset),
      .host_rd_data   (host_rd_data)
   );

   kv_mix_core #(
      .DATA_WIDTH(DATA_WIDTH)
   ) u_mix_core (
      .clk              (clk),
      .reset            (reset),
      .key_write_en     (key_write_en),
      .key_write_offset (key_write_offset),
      .key_write_data   (key_write_data),
      .src_write_en     (src_write_en),
      .src_write_offset (src_write_offset),
      .src_write_data   (src_write_data),
      .key_done         (key_done),
      .src_done         (src_done),
      .dest_done        (dest_done),
      .dest_data_avail  (dest_data_avail),
      .dest_data        (dest_data)
   );

   // a joint start with the destination armed finishes at a fixed latency
   assert property (@(posedge clk) disable iff (reset)
      ($rose(client_ctrl_reg.key_sel_en) && $rose(client_ctrl_reg.src_sel_en) &&
       client_ctrl_reg.dest_sel_en) |-> ##XFER_LATENCY dest_done);

endmodule

`default_nettype wire

//--- tb/kv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module kv_tb;
   import kv_pkg::*;

   localparam int DATA_WIDTH = 256;
   localparam int N          = DATA_WIDTH / 32;
   localparam int LATENCY    = 2 * N + 3;
   localparam int TIMEOUT    = 10 * LATENCY;

   logic                   clk;
   logic                   reset;
   kv_reg_t                ctrl;
   logic                   host_wr_en;
   logic                   host_wr_pcr;
   logic [KV_ENTRY_W-1:0]  host_wr_entry;
   logic [KV_OFFSET_W-1:0] host_wr_offset;
   logic [31:0]            host_wr_data;
   logic                   host_rd_pcr;
   logic [KV_ENTRY_W-1:0]  host_rd_entry;
   logic [KV_OFFSET_W-1:0] host_rd_offset;
   logic [31:0]            host_rd_data;
   logic                   key_done;
   logic                   src_done;
   logic                   dest_done;

   // shadow copy of the vault
   logic [31:0] key_model [KV_NUM_KEYS][KV_ENTRY_DWORDS];
   logic [31:0] pcr_model [KV_NUM_PCRS][KV_ENTRY_DWORDS];
   logic        key_vld_model [KV_NUM_KEYS];
   logic        pcr_vld_model [KV_NUM_PCRS];
   integer      seed;

   kv_subsys_top #(
      .DATA_WIDTH(DATA_WIDTH)
   ) dut (
      .clk             (clk),
      .reset           (reset),
      .client_ctrl_reg (ctrl),
      .host_wr_en      (host_wr_en),
      .host_wr_pcr     (host_wr_pcr),
      .host_wr_entry   (host_wr_entry),
      .host_wr_offset  (host_wr_offset),
      .host_wr_data    (host_wr_data),
      .host_rd_pcr     (host_rd_pcr),
      .host_rd_entry   (host_rd_entry),
      .host_rd_offset  (host_rd_offset),
      .host_rd_data    (host_rd_data),
      .key_done        (key_done),
      .src_done        (src_done),
      .dest_done       (dest_done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else
         report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      assert (got === exp) else
         report_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
   endtask

   function automatic logic [31:0] rotate_left_8(input logic [31:0] value);
      return {value[23:0], value[31:24]};
   endfunction

   // invalid entries read as zero
   function automatic logic [31:0] model_read(input logic is_pcr, input int entry,
                                              input int offset);
      logic [31:0] data;
      data = 32'h0;
      if (is_pcr) begin
         if (pcr_vld_model[entry]) begin
            data = pcr_model[entry][offset];
         end
      end else if (key_vld_model[entry]) begin
         data = key_model[entry][offset];
      end
      return data;
   endfunction

   task automatic model_write(input logic is_pcr, input int entry, input int offset,
                              input logic [31:0] data, input logic vld);
      if (is_pcr) begin
         pcr_model[entry][offset] = data;
         pcr_vld_model[entry]     = vld;
      end else begin
         key_model[entry][offset] = data;
         key_vld_model[entry]     = vld;
      end
   endtask

   task automatic seed_entry(input logic is_pcr, input int entry);
      logic [31:0] data;
      for (int i = 0; i < KV_ENTRY_DWORDS; i++) begin
         data = $random(seed);
         @(negedge clk);
         host_wr_en     = 1'b1;
         host_wr_pcr    = is_pcr;
         host_wr_entry  = KV_ENTRY_W'(entry);
         host_wr_offset = KV_OFFSET_W'(i);
         host_wr_data   = data;
         model_write(is_pcr, entry, i, data, 1'b1);
      end
      @(negedge clk);
      host_wr_en = 1'b0;
   endtask

   // key bank never shows through the host port
   task automatic check_host_read(input logic is_pcr, input int entry, input int offset);
      logic [31:0] expected;
      expected = is_pcr ? model_read(1'b1, entry, offset) : 32'h0;
      @(negedge clk);
      host_rd_pcr    = is_pcr;
      host_rd_entry  = KV_ENTRY_W'(entry);
      host_rd_offset = KV_OFFSET_W'(offset);
      #1;
      check_word($sformatf("host_rd_data %s %0d dword %0d", is_pcr ? "pcr" : "key",
                           entry, offset), host_rd_data, expected);
   endtask

   task automatic expect_quiet(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_flag("key_done", key_done, 1'b0);
         check_flag("src_done", src_done, 1'b0);
         check_flag("dest_done", dest_done, 1'b0);
      end
   endtask

   task automatic release_enables();
      @(negedge clk);
      ctrl.key_sel_en  = 1'b0;
      ctrl.src_sel_en  = 1'b0;
      ctrl.dest_sel_en = 1'b0;
      @(negedge clk);
   endtask

   // enables stay high on return
   task automatic run_transfer(input logic key_pcr, input int key_entry,
                               input logic src_pcr, input int src_entry,
                               input logic dest_pcr, input int dest_entry,
                               input logic dest_valid);
      logic [31:0] expected [N];
      int          cycles;
      for (int i = 0; i < N; i++) begin
         expected[i] = model_read(key_pcr, key_entry, i) ^
                       rotate_left_8(model_read(src_pcr, src_entry, i));
      end
      @(negedge clk);
      ctrl.key_sel_pcr  = key_pcr;
      ctrl.key_sel      = KV_ENTRY_W'(key_entry);
      ctrl.src_sel_pcr  = src_pcr;
      ctrl.src_sel      = KV_ENTRY_W'(src_entry);
      ctrl.dest_sel_pcr = dest_pcr;
      ctrl.dest_sel     = KV_ENTRY_W'(dest_entry);
      ctrl.dest_valid   = dest_valid;
      ctrl.dest_sel_en  = 1'b1;
      @(negedge clk);
      ctrl.key_sel_en = 1'b1;
      ctrl.src_sel_en = 1'b1;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            report_failure("timed out waiting for dest_done");
         end
      end while (!dest_done);
      assert (cycles == LATENCY) else
         report_failure($sformatf("CHECK FAILED at %0t: dest_done latency got %0d expected %0d",
                                  $time, cycles, LATENCY));
      for (int i = 0; i < N; i++) begin
         model_write(dest_pcr, dest_entry, i, expected[i], dest_valid);
      end
      for (int i = 0; i < N; i++) begin
         check_host_read(dest_pcr, dest_entry, i);
      end
   endtask

   // each done needs its own start edge
   assert property (@(posedge clk) disable iff (reset)
      key_done |-> ($past(ctrl.key_sel_en, N + 1) && !$past(ctrl.key_sel_en, N + 2)))
      else report_failure("key_done pulsed without a rising edge of key_sel_en");

   assert property (@(posedge clk) disable iff (reset)
      src_done |-> ($past(ctrl.src_sel_en, N + 1) && !$past(ctrl.src_sel_en, N + 2)))
      else report_failure("src_done pulsed without a rising edge of src_sel_en");

   assert property (@(posedge clk) disable iff (reset)
      dest_done |-> ($past(key_done, N + 2) && $past(src_done, N + 2)))
      else report_failure("dest_done pulsed without a finished key and source read");

   assert property (@(posedge clk) disable iff (reset)
      ($rose(ctrl.key_sel_en) && $rose(ctrl.src_sel_en) && ctrl.dest_sel_en)
      |-> ##LATENCY dest_done)
      else report_failure("dest_done missing at the fixed transfer latency");

   initial begin
      seed           = 32'hc9f8_3712;
      reset          = 1'b1;
      ctrl           = '0;
      host_wr_en     = 1'b0;
      host_wr_pcr    = 1'b0;
      host_wr_entry  = '0;
      host_wr_offset = '0;
      host_wr_data   = '0;
      host_rd_pcr    = 1'b0;
      host_rd_entry  = '0;
      host_rd_offset = '0;
      for (int e = 0; e < KV_NUM_KEYS; e++) begin
         key_vld_model[e] = 1'b0;
      end
      for (int e = 0; e < KV_NUM_PCRS; e++) begin
         pcr_vld_model[e] = 1'b0;
      end
      repeat (10) @(negedge clk);
      reset = 1'b0;

      // idle vault after reset
      expect_quiet(3 * N);
      for (int e = 0; e < KV_NUM_PCRS; e++) begin
         for (int i = 0; i < N; i++) begin
            check_host_read(1'b1, e, i);
         end
      end

      // all keys, PCR 0 and 1 seeded by the host
      for (int e = 0; e < KV_NUM_KEYS; e++) begin
         seed_entry(1'b0, e);
      end
      seed_entry(1'b1, 0);
      seed_entry(1'b1, 1);
      for (int e = 0; e < KV_NUM_PCRS; e++) begin
         for (int i = 0; i < N; i++) begin
            check_host_read(1'b1, e, i);
         end
      end
      for (int e = 0; e < KV_NUM_KEYS; e++) begin
         for (int i = 0; i < N; i++) begin
            check_host_read(1'b0, e, i);
         end
      end

      // key 2 with PCR 1 into PCR 2
      run_transfer(1'b0, 2, 1'b1, 1, 1'b1, 2, 1'b1);
      release_enables();

      // result into key 7, then chained through to PCR 3
      run_transfer(1'b0, 5, 1'b1, 0, 1'b0, 7, 1'b1);
      release_enables();
      run_transfer(1'b0, 3, 1'b0, 7, 1'b1, 3, 1'b1);
      release_enables();

      // PCR 0 left invalid, so key 4 passes straight into PCR 2
      run_transfer(1'b0, 1, 1'b1, 1, 1'b1, 0, 1'b0);
      release_enables();
      run_transfer(1'b0, 4, 1'b1, 0, 1'b1, 2, 1'b1);

      // held enables give no second transfer
      expect_quiet(4 * N);
      release_enables();
      run_transfer(1'b0, 6, 1'b1, 3, 1'b1, 1, 1'b1);
      release_enables();
      expect_quiet(2 * N);

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
